//--- Bender.yml
package:
  name: mam

export_include_dirs:
  - common

sources:
  - common/dii_pkg.sv
  - common/mam_pkg.sv
  - mam/mam_pkt_engine.sv
  - mam/mam_ahb_master.sv
  - design/mam_tl.sv
  - target: test
    files:
      - tb/ahb_mem_model.sv
      - tb/tb_mam_tl.sv

//--- common/dii_pkg.sv
// Debug interconnect flit type
// Type words of MAM request and response packets

package dii_pkg;

  // One flit on the debug interconnect
  // The valid bit travels inside the flit, ready travels beside it
  typedef struct packed {
    logic [15:0] data;
    logic        last;
    logic        valid;
  } dii_flit_t;

  // Third word of every packet, selects the packet handler
  localparam logic [15:0] DII_TYPE_MAM_REQ = 16'h0010;

  // Type word that the MAM puts on its own responses
  localparam logic [15:0] DII_TYPE_MAM_RSP = 16'h0011;

endpackage

//--- common/mam_config.svh
// Build-time configuration of the memory access module
// Data and address widths, packet length limit and the memory window
`ifndef MAM_CONFIG_SVH
`define MAM_CONFIG_SVH

// Width of one bus beat in bits, equal to one flit payload
`define XLEN 16

// Bus address width in bits, carried as two flits in a request
`define PLEN 32

// Longest packet in flits, header words included
`define MAX_PKT_LEN 12

// Byte window that debug requests may touch
// A request is executed only if every beat falls inside it
`define MEM_BASE 32'h0000_1000
`define MEM_SIZE 32'h0000_0200

`endif

//--- common/mam_pkg.sv
// MAM control word, engine to master request and AHB encodings
// Shared by the packet engine, the bus master and the testbench

package mam_pkg;

  `include "mam_config.svh"

  // Field view of the fourth request word
  typedef struct packed {
    logic        we;
    logic        burst;
    logic        sync;
    logic [12:0] beats;
  } mam_ctrl_t;

  // The same word as it arrives in a flit, or split into its fields
  typedef union packed {
    logic [15:0] raw;
    mam_ctrl_t   ctrl;
  } mam_ctrl_u;

  // One bus request from the packet engine to the AHB master
  // For a single access beats is one
  typedef struct packed {
    logic             we;
    logic             burst;
    logic [12:0]      beats;
    logic [`PLEN-1:0] addr;
  } mam_req_t;

  // AHB transfer types
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // AHB burst types
  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_INCR   = 3'b001;

  // Data access, privileged, not bufferable
  localparam logic [3:0] HPROT_DATA    = 4'b0011;

endpackage

//--- design/mam_tl.sv
// MAM top level
// Packet engine on the debug side, AHB-Lite master on the memory side
`timescale 1ns/10ps
`include "mam_config.svh"

module mam_tl
  import dii_pkg::*;
  import mam_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [15:0]       id_i,
  input  dii_flit_t         debug_in_i,
  output logic              debug_in_ready_o,
  output dii_flit_t         debug_out_o,
  input  logic              debug_out_ready_i,
  output logic              biu_hsel_o,
  output logic [`PLEN-1:0]  biu_haddr_o,
  output logic [`XLEN-1:0]  biu_hwdata_o,
  output logic              biu_hwrite_o,
  output logic [2:0]        biu_hsize_o,
  output logic [2:0]        biu_hburst_o,
  output logic [3:0]        biu_hprot_o,
  output logic [1:0]        biu_htrans_o,
  output logic              biu_hmastlock_o,
  input  logic [`XLEN-1:0]  biu_hrdata_i,
  input  logic              biu_hready_i,
  input  logic              biu_hresp_i
);

  // Request channel between engine and master
  mam_req_t          req;
  logic              req_valid;
  logic              req_ready;

  // Per-beat write and read channels
  logic [`XLEN-1:0]  wdata;
  logic              wvalid;
  logic              wready;
  logic [`XLEN-1:0]  rdata;
  logic              rvalid;
  logic              rready;

  mam_pkt_engine u_engine (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .id_i              (id_i),
    .debug_in_i        (debug_in_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .debug_out_o       (debug_out_o),
    .debug_out_ready_i (debug_out_ready_i),
    .req_o             (req),
    .req_valid_o       (req_valid),
    .req_ready_i       (req_ready),
    .wdata_o           (wdata),
    .wvalid_o          (wvalid),
    .wready_i          (wready),
    .rdata_i           (rdata),
    .rvalid_i          (rvalid),
    .rready_o          (rready)
  );

  mam_ahb_master u_master (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .wdata_i         (wdata),
    .wvalid_i        (wvalid),
    .wready_o        (wready),
    .rdata_o         (rdata),
    .rvalid_o        (rvalid),
    .rready_i        (rready),
    .biu_hsel_o      (biu_hsel_o),
    .biu_haddr_o     (biu_haddr_o),
    .biu_hwdata_o    (biu_hwdata_o),
    .biu_hwrite_o    (biu_hwrite_o),
    .biu_hsize_o     (biu_hsize_o),
    .biu_hburst_o    (biu_hburst_o),
    .biu_hprot_o     (biu_hprot_o),
    .biu_htrans_o    (biu_htrans_o),
    .biu_hmastlock_o (biu_hmastlock_o),
    .biu_hrdata_i    (biu_hrdata_i),
    .biu_hready_i    (biu_hready_i),
    .biu_hresp_i     (biu_hresp_i)
  );

endmodule

//--- mam/mam_ahb_master.sv
// AHB-Lite master of the MAM
// Runs single transfers and incrementing bursts one beat at a time
`timescale 1ns/10ps
`include "mam_config.svh"

module mam_ahb_master
  import mam_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  mam_req_t          req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [`XLEN-1:0]  wdata_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output logic [`XLEN-1:0]  rdata_o,
  output logic              rvalid_o,
  input  logic              rready_i,
  output logic              biu_hsel_o,
  output logic [`PLEN-1:0]  biu_haddr_o,
  output logic [`XLEN-1:0]  biu_hwdata_o,
  output logic              biu_hwrite_o,
  output logic [2:0]        biu_hsize_o,
  output logic [2:0]        biu_hburst_o,
  output logic [3:0]        biu_hprot_o,
  output logic [1:0]        biu_htrans_o,
  output logic              biu_hmastlock_o,
  input  logic [`XLEN-1:0]  biu_hrdata_i,
  input  logic              biu_hready_i,
  input  logic              biu_hresp_i
);

  // Every beat moves a full bus word
  localparam logic [2:0] HSIZE = 3'($clog2(`XLEN / 8));

  logic               act_q;
  logic [1:0]         htrans_q;
  logic               hsel_q;
  logic               dph_q;
  logic               rvalid_q;

  logic               we_q;
  logic               burst_q;
  logic [12:0]        beats_q;
  logic [`PLEN-1:0]   addr_q;
  logic [`PLEN-1:0]   haddr_q;
  logic               hwrite_q;
  logic [`XLEN-1:0]   rdata_q;

  logic               addr_ph;
  logic               addr_ack;
  logic               data_ack;
  logic               rd_free;
  logic               issue;

  assign addr_ph  = (htrans_q != HTRANS_IDLE);
  assign addr_ack = addr_ph && biu_hready_i;
  assign data_ack = dph_q && biu_hready_i;

  // Held read data must be taken before the next read address goes out
  assign rd_free  = !rvalid_q || rready_i;

  // Only one beat is on the bus, so each beat opens with NONSEQ
  assign issue = act_q && (beats_q != 13'd0) && !addr_ph && !dph_q && biu_hready_i &&
                 (we_q ? wvalid_i : rd_free);

  assign req_ready_o = !act_q;
  assign wready_o    = data_ack && we_q;
  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;

  assign biu_hsel_o      = hsel_q;
  assign biu_htrans_o    = htrans_q;
  assign biu_haddr_o     = haddr_q;
  assign biu_hwrite_o    = hwrite_q;
  assign biu_hwdata_o    = wdata_i;
  assign biu_hsize_o     = HSIZE;
  assign biu_hburst_o    = burst_q ? HBURST_INCR : HBURST_SINGLE;
  assign biu_hprot_o     = HPROT_DATA;
  assign biu_hmastlock_o = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // Beat sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      act_q    <= 1'b0;
      htrans_q <= HTRANS_IDLE;
      hsel_q   <= 1'b0;
      dph_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        act_q <= 1'b1;
      end else if (data_ack && beats_q == 13'd0) begin
        act_q <= 1'b0;
      end
      // Address phase ends on hready, the data phase follows
      if (issue) begin
        htrans_q <= HTRANS_NONSEQ;
        hsel_q   <= 1'b1;
      end else if (addr_ack) begin
        htrans_q <= HTRANS_IDLE;
        hsel_q   <= 1'b0;
      end
      if (addr_ack) begin
        dph_q <= 1'b1;
      end else if (data_ack) begin
        dph_q <= 1'b0;
      end
      if (data_ack && !we_q) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q    <= req_i.we;
      burst_q <= req_i.burst;
      beats_q <= req_i.beats;
      addr_q  <= req_i.addr;
    end else if (addr_ack) begin
      beats_q <= beats_q - 13'd1;
      addr_q  <= addr_q + (`XLEN / 8);
    end
    if (issue) begin
      haddr_q  <= addr_q;
      hwrite_q <= we_q;
    end
    if (data_ack && !we_q) begin
      rdata_q <= biu_hrdata_i;
    end
  end

  // A held read beat keeps the bus idle until the engine takes it
  a_idle_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |-> biu_htrans_o == HTRANS_IDLE);

  // A waited address phase keeps its address and type
  a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (biu_htrans_o != HTRANS_IDLE) && !biu_hready_i |=>
      $stable(biu_haddr_o) && $stable(biu_htrans_o));

  // The slave in the window is expected never to answer with ERROR
  a_no_error: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dph_q |-> !biu_hresp_i);

endmodule

//--- mam/mam_pkt_engine.sv
// MAM packet engine
// Parses request packets, issues bus beats and builds response packets
`timescale 1ns/10ps
`include "mam_config.svh"

module mam_pkt_engine
  import dii_pkg::*;
  import mam_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [15:0]       id_i,
  input  dii_flit_t         debug_in_i,
  output logic              debug_in_ready_o,
  output dii_flit_t         debug_out_o,
  input  logic              debug_out_ready_i,
  output mam_req_t          req_o,
  output logic              req_valid_o,
  input  logic              req_ready_i,
  output logic [`XLEN-1:0]  wdata_o,
  output logic              wvalid_o,
  input  logic              wready_i,
  input  logic [`XLEN-1:0]  rdata_i,
  input  logic              rvalid_i,
  output logic              rready_o
);

  // Data flits that fit behind the three header words
  localparam int PKT_BEATS = `MAX_PKT_LEN - 3;
  localparam int PKT_W     = $clog2(`MAX_PKT_LEN);

  typedef enum logic [3:0] {
    ST_INIT, ST_HDR, ST_CHECK, ST_DROP, ST_REQ,
    ST_WRITE, ST_RWAIT, ST_RHDR, ST_RDATA, ST_ACK
  } state_e;

  state_e             state_q;
  logic [2:0]         hdr_cnt_q;
  logic [1:0]         out_cnt_q;
  logic [12:0]        beats_q;
  logic [PKT_W-1:0]   pkt_q;

  logic [15:0]        src_q;
  logic               type_ok_q;
  mam_ctrl_u          ctrl_q;
  logic [`PLEN-1:0]   addr_q;
  logic               last_q;

  logic               in_xfer;
  logic               out_xfer;
  logic [12:0]        req_beats;
  logic [`PLEN:0]     acc_end;
  logic               in_win;
  logic               req_ok;
  logic               rd_last;
  logic [15:0]        hdr_word;

  assign in_xfer  = debug_in_i.valid && debug_in_ready_o;
  assign out_xfer = debug_out_o.valid && debug_out_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////

  // A single access always moves exactly one beat
  assign req_beats = ctrl_q.ctrl.burst ? ctrl_q.ctrl.beats : 13'd1;

  // End address one past the last byte, one spare bit catches wrap-around
  assign acc_end = {1'b0, addr_q} + {{(`PLEN - 13){1'b0}}, req_beats, 1'b0};
  assign in_win  = (addr_q >= `MEM_BASE) &&
                   (acc_end <= ({1'b0, `MEM_BASE} + {1'b0, `MEM_SIZE}));

  // Writes must carry data flits, reads must end on the address word
  assign req_ok = type_ok_q && in_win && (req_beats != 13'd0) && !addr_q[0] &&
                  (ctrl_q.ctrl.we != last_q);

  assign req_o = '{we: ctrl_q.ctrl.we, burst: ctrl_q.ctrl.burst, beats: req_beats,
                   addr: addr_q};
  assign req_valid_o = (state_q == ST_REQ);

  // Header words are captured as they stream in; word 0 is our own address
  always_ff @(posedge clk_i) begin
    if (state_q == ST_HDR && in_xfer) begin
      case (hdr_cnt_q)
        3'd1: src_q <= debug_in_i.data;
        3'd2: type_ok_q <= (debug_in_i.data == DII_TYPE_MAM_REQ);
        3'd3: ctrl_q.raw <= debug_in_i.data;
        3'd4: addr_q[`PLEN-1:`PLEN/2] <= debug_in_i.data;
        3'd5: begin
          addr_q[`PLEN/2-1:0] <= debug_in_i.data;
          last_q              <= debug_in_i.last;
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flit and beat handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Input is taken while parsing or dropping, and one flit per write beat
  always_comb begin
    case (state_q)
      ST_HDR, ST_DROP: debug_in_ready_o = 1'b1;
      ST_WRITE:        debug_in_ready_o = wready_i;
      default:         debug_in_ready_o = 1'b0;
    endcase
  end

  // Write data goes straight from the held flit to the bus
  assign wdata_o  = debug_in_i.data;
  assign wvalid_o = (state_q == ST_WRITE) && debug_in_i.valid;

  // A read beat is released only when its flit leaves
  assign rready_o = (state_q == ST_RDATA) && rvalid_i && debug_out_ready_i;

  // Last data flit of the whole burst or of the current response packet
  assign rd_last = (beats_q == 13'd1) || (pkt_q == PKT_W'(1));

  // Response header is the requester, then us, then the response type
  always_comb begin
    case (out_cnt_q)
      2'd0:    hdr_word = src_q;
      2'd1:    hdr_word = id_i;
      default: hdr_word = DII_TYPE_MAM_RSP;
    endcase
  end

  always_comb begin
    case (state_q)
      ST_RHDR:  debug_out_o = '{data: hdr_word, last: 1'b0, valid: 1'b1};
      ST_ACK:   debug_out_o = '{data: hdr_word, last: (out_cnt_q == 2'd2), valid: 1'b1};
      ST_RDATA: debug_out_o = '{data: rdata_i, last: rd_last, valid: rvalid_i};
      default:  debug_out_o = '{data: rdata_i, last: 1'b0, valid: 1'b0};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Engine FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_INIT;
      hdr_cnt_q <= '0;
      out_cnt_q <= '0;
      beats_q   <= '0;
      pkt_q     <= '0;
    end else begin
      case (state_q)
        // Holds input ready low for the first cycle out of reset
        ST_INIT: state_q <= ST_HDR;
        ST_HDR: begin
          if (in_xfer) begin
            if (hdr_cnt_q == 3'd5) begin
              hdr_cnt_q <= '0;
              state_q   <= ST_CHECK;
            end else if (debug_in_i.last) begin
              // Packet too short to be a request, start over
              hdr_cnt_q <= '0;
            end else begin
              hdr_cnt_q <= hdr_cnt_q + 3'd1;
            end
          end
        end
        ST_CHECK: begin
          beats_q <= req_beats;
          pkt_q   <= PKT_W'(PKT_BEATS);
          if (req_ok) begin
            state_q <= ST_REQ;
          end else if (last_q) begin
            state_q <= ST_HDR;
          end else begin
            state_q <= ST_DROP;
          end
        end
        // Swallow the rest of a rejected packet
        ST_DROP: begin
          if (in_xfer && debug_in_i.last) begin
            state_q <= ST_HDR;
          end
        end
        ST_REQ: begin
          if (req_ready_i) begin
            state_q <= ctrl_q.ctrl.we ? ST_WRITE : ST_RWAIT;
          end
        end
        ST_WRITE: begin
          if (in_xfer) begin
            beats_q <= beats_q - 13'd1;
            if (beats_q == 13'd1) begin
              state_q <= ctrl_q.ctrl.sync ? ST_ACK : ST_HDR;
            end
          end
        end
        // Each response packet waits for its first beat before the header
        ST_RWAIT: begin
          if (rvalid_i) begin
            state_q <= ST_RHDR;
          end
        end
        ST_RHDR: begin
          if (out_xfer) begin
            if (out_cnt_q == 2'd2) begin
              out_cnt_q <= '0;
              state_q   <= ST_RDATA;
            end else begin
              out_cnt_q <= out_cnt_q + 2'd1;
            end
          end
        end
        ST_RDATA: begin
          if (out_xfer) begin
            beats_q <= beats_q - 13'd1;
            pkt_q   <= pkt_q - PKT_W'(1);
            if (beats_q == 13'd1) begin
              state_q <= ST_HDR;
            end else if (pkt_q == PKT_W'(1)) begin
              // Burst continues in a fresh response packet
              pkt_q   <= PKT_W'(PKT_BEATS);
              state_q <= ST_RWAIT;
            end
          end
        end
        ST_ACK: begin
          if (out_xfer) begin
            if (out_cnt_q == 2'd2) begin
              out_cnt_q <= '0;
              state_q   <= ST_HDR;
            end else begin
              out_cnt_q <= out_cnt_q + 2'd1;
            end
          end
        end
        default: state_q <= ST_HDR;
      endcase
    end
  end

  // A stalled flit holds, read data included, until it is taken
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_out_o.valid && !debug_out_ready_i |=> $stable(debug_out_o));

  // An offered read beat stays offered with the same data until it is taken
  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_o |=> rvalid_i && $stable(rdata_i));

endmodule

//--- sources.f
+incdir+common
common/dii_pkg.sv
common/mam_pkg.sv
mam/mam_pkt_engine.sv
mam/mam_ahb_master.sv
design/mam_tl.sv
tb/ahb_mem_model.sv
tb/tb_mam_tl.sv

//--- tb/ahb_mem_model.sv
// AHB-Lite slave memory for the MAM testbench
// 256 words behind MEM_BASE, with 0 to 3 random wait states per data phase
`timescale 1ns/10ps
`include "mam_config.svh"

module ahb_mem_model (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              hsel_i,
  input  logic [`PLEN-1:0]  haddr_i,
  input  logic              hwrite_i,
  input  logic [1:0]        htrans_i,
  input  logic [`XLEN-1:0]  hwdata_i,
  output logic [`XLEN-1:0]  hrdata_o,
  output logic              hready_o,
  output logic              hresp_o
);

  logic [`XLEN-1:0] mem [0:255];

  logic        dph_q;
  logic        dwrite_q;
  logic [7:0]  didx_q;
  logic [1:0]  wait_q;

  // Each word starts from its own index, upper byte inverted
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {~8'(i), 8'(i)};
    end
  end

  // Outside a data phase the slave is always ready
  assign hready_o = !dph_q || (wait_q == 2'd0);
  assign hrdata_o = mem[didx_q];
  assign hresp_o  = 1'b0;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dph_q    <= 1'b0;
      dwrite_q <= 1'b0;
      didx_q   <= '0;
      wait_q   <= '0;
    end else if (hready_o) begin
      // Write data lands as its data phase completes
      if (dph_q && dwrite_q) begin
        mem[didx_q] <= hwdata_i;
      end
      // NONSEQ and SEQ both have the upper htrans bit set
      dph_q    <= hsel_i && htrans_i[1];
      dwrite_q <= hwrite_i;
      didx_q   <= 8'((haddr_i - `MEM_BASE) >> 1);
      wait_q   <= 2'($urandom_range(3, 0));
    end else begin
      wait_q <= wait_q - 2'd1;
    end
  end

endmodule

//--- tb/tb_mam_tl.sv
// MAM testbench with clock, reset, request packets and response checks
// Drives mam_tl against an AHB-Lite memory model with random wait states
`timescale 1ns/10ps
`include "mam_config.svh"

module tb_mam_tl
  import dii_pkg::*;
  import mam_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int FLIT_TIMEOUT = 1000;
  localparam int RSP_TIMEOUT  = 5000;
  localparam int QUIET_CYCLES = 60;
  localparam int RUN_LIMIT    = 200000;
  localparam int PKT_BEATS    = `MAX_PKT_LEN - 3;
  localparam logic [15:0] MAM_ID  = 16'h0002;
  localparam logic [15:0] HOST_ID = 16'h0001;

  // AHB size code of a 16-bit transfer
  localparam logic [2:0]  HSIZE_HALF = 3'b001;

  logic              clk;
  logic              rst_n;
  dii_flit_t         debug_in;
  logic              debug_in_ready;
  dii_flit_t         debug_out;
  logic              debug_out_ready;
  logic              hsel;
  logic [`PLEN-1:0]  haddr;
  logic [`XLEN-1:0]  hwdata;
  logic              hwrite;
  logic [2:0]        hsize;
  logic [2:0]        hburst;
  logic [3:0]        hprot;
  logic [1:0]        htrans;
  logic              hmastlock;
  logic [`XLEN-1:0]  hrdata;
  logic              hready;
  logic              hresp;

  // Reference memory and the response flits still owed by the DUT
  logic [15:0]       ref_mem [0:255];
  dii_flit_t         exp_q [$];
  dii_flit_t         exp_head;
  logic              exp_pending;
  logic [15:0]       wr_data_q [$];

  // Direction and burst type of the request that owns the bus
  logic              cur_we;
  logic [2:0]        cur_hburst;

  logic              in_taken;
  logic              req_sent;
  logic              drop_check;
  logic              rand_ready;
  int                errors;
  int                test_errors;
  int                tests_run;
  int                tests_failed;

  mam_tl uut (
    .clk_i (clk), .rst_n_i (rst_n), .id_i (MAM_ID),
    .debug_in_i (debug_in), .debug_in_ready_o (debug_in_ready),
    .debug_out_o (debug_out), .debug_out_ready_i (debug_out_ready),
    .biu_hsel_o (hsel), .biu_haddr_o (haddr), .biu_hwdata_o (hwdata),
    .biu_hwrite_o (hwrite), .biu_hsize_o (hsize), .biu_hburst_o (hburst),
    .biu_hprot_o (hprot), .biu_htrans_o (htrans), .biu_hmastlock_o (hmastlock),
    .biu_hrdata_i (hrdata), .biu_hready_i (hready), .biu_hresp_i (hresp)
  );

  ahb_mem_model u_mem (
    .clk_i (clk), .rst_n_i (rst_n), .hsel_i (hsel), .haddr_i (haddr),
    .hwrite_i (hwrite), .htrans_i (htrans), .hwdata_i (hwdata),
    .hrdata_o (hrdata), .hready_o (hready), .hresp_o (hresp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(RUN_LIMIT * CLK_PERIOD);
    $display("run stopped after %0d cycles without finishing", RUN_LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake monitors and checks
  ////////////////////////////////////////////////////////////////////////////

  // The queue head moves on at the rising edge of each accepted flit
  always @(posedge clk) begin
    in_taken <= debug_in.valid && debug_in_ready;
    if (rst_n && debug_out.valid && debug_out_ready && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
  end

  // Head is refreshed half a cycle later, output ready toggles in test 5
  always @(negedge clk) begin
    exp_pending = (exp_q.size() != 0);
    exp_head = exp_pending ? exp_q[0] : '0;
    debug_out_ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  a_flit_expected: assert property (@(posedge clk) disable iff (!rst_n)
    debug_out.valid && debug_out_ready |-> exp_pending)
    else begin
      errors++;
      $display("response flit %h arrived when none was expected", $sampled(debug_out.data));
    end

  a_flit_match: assert property (@(posedge clk) disable iff (!rst_n)
    debug_out.valid && debug_out_ready && exp_pending |->
      debug_out.data == exp_head.data && debug_out.last == exp_head.last)
    else begin
      errors++;
      $display("mismatch debug_out_o: expected data %h last %h, got data %h last %h",
               $sampled(exp_head.data), $sampled(exp_head.last),
               $sampled(debug_out.data), $sampled(debug_out.last));
    end

  // A stalled flit keeps its contents until the next cycle
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    debug_out.valid && !debug_out_ready |=> $stable(debug_out))
    else begin
      errors++;
      $display("stalled response flit changed before it was accepted");
    end

  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !req_sent |-> !hsel && htrans == HTRANS_IDLE && !debug_out.valid)
    else begin
      errors++;
      $display("bus or debug output became active before any request");
    end

  a_no_bus_on_drop: assert property (@(posedge clk) disable iff (!rst_n)
    drop_check |-> !hsel && htrans == HTRANS_IDLE)
    else begin
      errors++;
      $display("bus transfer started for a request outside the window");
    end

  // Each address phase is a halfword with the request's direction and burst type
  a_addr_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    htrans != HTRANS_IDLE |->
      hsize == HSIZE_HALF && hwrite == cur_we && hburst == cur_hburst)
    else begin
      errors++;
      $display("mismatch biu_hsize_o %h biu_hwrite_o %h biu_hburst_o %h, expected %h %h %h",
               $sampled(hsize), $sampled(hwrite), $sampled(hburst),
               HSIZE_HALF, $sampled(cur_we), $sampled(cur_hburst));
    end

  // Transfers are never locked and the protection code never changes
  a_fixed_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    !hmastlock && $stable(hprot))
    else begin
      errors++;
      $display("mismatch biu_hmastlock_o %h expected 0, biu_hprot_o %h changed",
               $sampled(hmastlock), $sampled(hprot));
    end

  ////////////////////////////////////////////////////////////////////////////
  // Packet tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] word_index(input logic [`PLEN-1:0] addr);
    return 8'((addr - `MEM_BASE) >> 1);
  endfunction

  // Every byte of the access must lie inside the window
  function automatic logic in_window(input logic [`PLEN-1:0] addr, input int beats);
    longint unsigned offset;
    offset = addr - `MEM_BASE;
    return (addr >= `MEM_BASE) && !addr[0] && (offset + 2 * beats <= `MEM_SIZE);
  endfunction

  task automatic expect_flit(input logic [15:0] data, input logic last);
    exp_q.push_back('{data: data, last: last, valid: 1'b1});
  endtask

  task automatic expect_header(input logic last);
    expect_flit(HOST_ID, 1'b0);
    expect_flit(MAM_ID, 1'b0);
    expect_flit(DII_TYPE_MAM_RSP, last);
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_flit(input logic [15:0] data, input logic last);
    int cycles;
    cycles = 0;
    req_sent = 1'b1;
    debug_in = '{data: data, last: last, valid: 1'b1};
    do begin
      @(negedge clk);
      cycles++;
    end while (!in_taken && cycles < FLIT_TIMEOUT);
    if (!in_taken) begin
      errors++;
      $display("input flit %h not accepted within %0d cycles", data, FLIT_TIMEOUT);
    end
    debug_in.valid = 1'b0;
  endtask

  // Write data comes from wr_data_q, one entry per beat
  task automatic send_request(input logic we, input logic burst, input logic sync,
                              input int beats, input logic [`PLEN-1:0] addr);
    mam_ctrl_u ctrl;
    int n;
    n = burst ? beats : 1;
    ctrl.ctrl.we    = we;
    ctrl.ctrl.burst = burst;
    ctrl.ctrl.sync  = sync;
    ctrl.ctrl.beats = 13'(beats);
    if (in_window(addr, n) && we) begin
      for (int i = 0; i < n; i++) begin
        ref_mem[word_index(addr + 32'(2 * i))] = wr_data_q[i];
      end
      if (sync) begin
        expect_header(1'b1);
      end
    end else if (in_window(addr, n)) begin
      // Long reads come back as several packets of at most PKT_BEATS beats
      for (int i = 0; i < n; i++) begin
        if (i % PKT_BEATS == 0) begin
          expect_header(1'b0);
        end
        expect_flit(ref_mem[word_index(addr + 32'(2 * i))],
                    (i == n - 1) || (i % PKT_BEATS == PKT_BEATS - 1));
      end
    end
    send_flit(MAM_ID, 1'b0);
    // The previous request has left the bus once a new header flit is taken
    cur_we     = we;
    cur_hburst = burst ? HBURST_INCR : HBURST_SINGLE;
    send_flit(HOST_ID, 1'b0);
    send_flit(DII_TYPE_MAM_REQ, 1'b0);
    send_flit(ctrl.raw, 1'b0);
    send_flit(addr[31:16], 1'b0);
    send_flit(addr[15:0], !we);
    if (we) begin
      for (int i = 0; i < n; i++) begin
        send_flit(wr_data_q[i], i == n - 1);
      end
    end
    wr_data_q.delete();
  endtask

  task automatic wait_responses();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < RSP_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d response flits missing after %0d cycles", exp_q.size(), RSP_TIMEOUT);
      exp_q.delete();
    end
  endtask

  // Any flit in this window is caught by a_flit_expected
  task automatic quiet_wait(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
    end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int seed_draw;
    int n;
    logic [`PLEN-1:0] addr;
    seed_draw = $urandom(32'he80c);
    rst_n = 1'b0;
    debug_in = '0;
    debug_out_ready = 1'b1;
    req_sent = 1'b0;
    drop_check = 1'b0;
    rand_ready = 1'b0;
    cur_we = 1'b0;
    cur_hburst = HBURST_SINGLE;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = {~8'(i), 8'(i)};
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    quiet_wait(20);
    close_test("idle after reset");

    wr_data_q.push_back(16'hbeef);
    send_request(1'b1, 1'b0, 1'b0, 1, 32'h0000_1010);
    send_request(1'b0, 1'b0, 1'b0, 1, 32'h0000_1010);
    wait_responses();
    close_test("single write and read");

    for (int i = 0; i < 4; i++) begin
      wr_data_q.push_back(16'h3000 + 16'(i));
    end
    send_request(1'b1, 1'b1, 1'b0, 4, 32'h0000_1020);
    send_request(1'b0, 1'b1, 1'b0, 4, 32'h0000_1020);
    send_request(1'b0, 1'b1, 1'b0, 10, 32'h0000_1000);
    wait_responses();
    close_test("burst write and split read");

    wr_data_q.push_back(16'h5a5a);
    send_request(1'b1, 1'b0, 1'b1, 1, 32'h0000_1040);
    wait_responses();
    wr_data_q.push_back(16'h1234);
    wr_data_q.push_back(16'h5678);
    send_request(1'b1, 1'b1, 1'b0, 2, 32'h0000_1044);
    quiet_wait(QUIET_CYCLES);
    send_request(1'b0, 1'b1, 1'b0, 2, 32'h0000_1044);
    wait_responses();
    close_test("sync and non-sync write");

    // Random bursts inside the window under output back-pressure
    rand_ready = 1'b1;
    for (int k = 0; k < 6; k++) begin
      addr = `MEM_BASE + 32'($urandom_range(200, 0)) * 2;
      n = $urandom_range(12, 1);
      if (k % 2 == 0) begin
        for (int i = 0; i < n; i++) begin
          wr_data_q.push_back(16'($urandom));
        end
        send_request(1'b1, 1'b1, 1'b0, n, addr);
      end
      send_request(1'b0, 1'b1, 1'b0, n, addr);
      wait_responses();
    end
    rand_ready = 1'b0;
    close_test("reads under back-pressure");

    drop_check = 1'b1;
    for (int i = 0; i < 4; i++) begin
      wr_data_q.push_back(16'hdead);
    end
    send_request(1'b1, 1'b1, 1'b0, 4, 32'h0000_11fc);
    wr_data_q.push_back(16'hdead);
    send_request(1'b1, 1'b0, 1'b1, 1, 32'h0000_2000);
    send_request(1'b0, 1'b0, 1'b0, 1, 32'h0000_0ff0);
    quiet_wait(QUIET_CYCLES);
    drop_check = 1'b0;
    send_request(1'b0, 1'b1, 1'b0, 2, 32'h0000_11fc);
    wait_responses();
    close_test("requests outside the window");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
